// ==== sources.f ====
+incdir+hdl
hdl/io_pred_pkg.sv
hdl/io_port_check.sv
hdl/io_read_predication.sv
hdl/io_write_predication.sv
hdl/io_ready_gate.sv
hdl/io_predication_top.sv
test/io_predication_sva.sv
test/io_predication_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := io_predication_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Something failed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh test/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/io_predication_tb.sv ====
// I/O predication testbench
// Runs a request table through the stage and checks each result two cycles later

`include "io_pred_defs.svh"

module io_predication_tb;

    import io_pred_pkg::*;

    localparam int num_directed = 16;
    localparam int num_rows     = num_directed + 16;
    localparam int reset_cycles = 2;
    localparam int period       = 8;

    // Stage outputs for one request, as the model predicts them
    typedef struct packed {
        logic                      io_ready;
        logic [`IO_PORT_COUNT-1:0] rden;
        logic [`IO_PORT_COUNT-1:0] wren;
        logic                      read_is_io;
        logic [`IO_DATA_WIDTH-1:0] wdata;
    } expected_t;

    logic                      clock;
    logic                      rst_n;
    io_request_t               request;
    logic [`IO_PORT_COUNT-1:0] read_status;
    logic [`IO_PORT_COUNT-1:0] write_status;
    logic                      io_ready;
    logic [`IO_PORT_COUNT-1:0] rden;
    logic [`IO_PORT_COUNT-1:0] wren;
    logic [`IO_DATA_WIDTH-1:0] wdata;
    logic                      read_is_io;

    // Stimulus table, one row per cycle
    string                     row_name [num_rows];
    io_request_t               row_request [num_rows];
    logic [`IO_PORT_COUNT-1:0] row_read_status [num_rows];
    logic [`IO_PORT_COUNT-1:0] row_write_status [num_rows];

    // Predictions wait here for the two pipeline stages
    expected_t   expected_q [$];
    string       name_q [$];
    int          tests_run;
    int          tests_failed;
    int unsigned seed_sink;

    io_predication_top i_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .request      (request),
        .read_status  (read_status),
        .write_status (write_status),
        .io_ready     (io_ready),
        .rden         (rden),
        .wren         (wren),
        .wdata        (wdata),
        .read_is_io   (read_is_io)
    );

    always #(period / 2) clock = ~clock;

    // Table length plus reset plus a little slack
    initial begin
        #((num_rows + reset_cycles + 10) * period);
        $display("Timeout: the request table did not run to the end in time");
        $display("Something failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Reference model

    // Offset into the port window decides I/O, then each side's polarity decides the stall
    function automatic expected_t predict(io_request_t req, logic [`IO_PORT_COUNT-1:0] rs,
                                          logic [`IO_PORT_COUNT-1:0] ws);
        expected_t exp;
        int        rport;
        int        wport;
        logic      blocked;
        rport = int'(req.read_addr) - int'(`IO_PORT_BASE);
        wport = int'(req.write_addr) - int'(`IO_PORT_BASE);
        if (!req.valid || rport < 0 || rport >= `IO_PORT_COUNT) begin
            rport = -1;
        end
        if (!req.valid || wport < 0 || wport >= `IO_PORT_COUNT) begin
            wport = -1;
        end
        // An empty read port or a full write port stalls the whole instruction
        blocked = (rport >= 0 && !rs[rport[`IO_PORT_INDEX_WIDTH-1:0]]) ||
                  (wport >= 0 && ws[wport[`IO_PORT_INDEX_WIDTH-1:0]]);
        exp            = '0;
        exp.io_ready   = !blocked;
        exp.read_is_io = (rport >= 0);
        exp.wdata      = req.write_data;
        if (!blocked && rport >= 0) begin
            exp.rden[rport[`IO_PORT_INDEX_WIDTH-1:0]] = 1'b1;
        end
        if (!blocked && wport >= 0) begin
            exp.wren[wport[`IO_PORT_INDEX_WIDTH-1:0]] = 1'b1;
        end
        return exp;
    endfunction

    // ------------------------------------------------------------------
    // Table

    task automatic set_row(input int row, input string name, input logic valid,
                           input logic [`IO_ADDR_WIDTH-1:0] raddr,
                           input logic [`IO_ADDR_WIDTH-1:0] waddr,
                           input logic [`IO_DATA_WIDTH-1:0] data,
                           input logic [`IO_PORT_COUNT-1:0] rs,
                           input logic [`IO_PORT_COUNT-1:0] ws);
        row_name[row]         = name;
        row_request[row]      = {valid, raddr, waddr, data};
        row_read_status[row]  = rs;
        row_write_status[row] = ws;
    endtask

    task automatic fill_table();
        int k;
        set_row(0, "invalid_in_window", 1'b0, 10'h3F1, 10'h3F2, 16'h1111, 4'h0, 4'hF);
        set_row(1, "outside_below", 1'b1, 10'h123, 10'h3EF, 16'h2222, 4'h0, 4'hF);
        set_row(2, "outside_above", 1'b1, 10'h3F4, 10'h000, 16'h3333, 4'h0, 4'hF);
        for (k = 0; k < `IO_PORT_COUNT; k++) begin
            set_row(3 + k, $sformatf("read_port%0d_full", k), 1'b1,
                    10'(int'(`IO_PORT_BASE) + k), 10'h100, 16'hA000 + 16'(k),
                    4'b1 << k, 4'hF);
            set_row(8 + k, $sformatf("write_port%0d_room", k), 1'b1, 10'h080,
                    10'(int'(`IO_PORT_BASE) + k), 16'hB000 + 16'(k), 4'h0, ~(4'b1 << k));
        end
        set_row(7, "read_port2_empty", 1'b1, 10'h3F2, 10'h100, 16'h4444, 4'b1011, 4'hF);
        set_row(12, "write_port1_full", 1'b1, 10'h080, 10'h3F1, 16'h5555, 4'h0, 4'b0010);
        set_row(13, "read_ok_write_full", 1'b1, 10'h3F0, 10'h3F3, 16'h6666, 4'hF, 4'hF);
        set_row(14, "read_empty_write_ok", 1'b1, 10'h3F3, 10'h3F0, 16'h7777, 4'h0, 4'h0);
        set_row(15, "both_ready", 1'b1, 10'h3F1, 10'h3F2, 16'h8888, 4'hF, 4'h0);
        // Random tail, addresses from four below the window to four above it
        for (k = num_directed; k < num_rows; k++) begin
            set_row(k, $sformatf("random_%0d", k - num_directed), ($urandom % 4) != 0,
                    10'(int'(`IO_PORT_BASE) - 4 + int'($urandom % 12)),
                    10'(int'(`IO_PORT_BASE) - 4 + int'($urandom % 12)),
                    16'($urandom), 4'($urandom), 4'($urandom));
        end
    endtask

    // ------------------------------------------------------------------
    // Checking

    // All output fields of one result as a single line of text
    function automatic string format_outputs(expected_t v);
        return $sformatf("ready=%b rden=%b wren=%b is_io=%b wdata=%h", v.io_ready, v.rden,
                         v.wren, v.read_is_io, v.wdata);
    endfunction

    task automatic check_outputs();
        expected_t exp;
        expected_t got;
        string     name;
        bit        ok;
        exp  = expected_q.pop_front();
        name = name_q.pop_front();
        got  = {io_ready, rden, wren, read_is_io, wdata};
        ok   = 1'b1;
        tests_run++;
        assert (got === exp) else begin
            ok = 1'b0;
            $display("FAIL %s expected %s actual %s", name, format_outputs(exp),
                     format_outputs(got));
        end
        if (ok) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
        end
    endtask

    initial begin
        int row;
        clock        = 1'b0;
        rst_n        = 1'b0;
        request      = '0;
        read_status  = '0;
        write_status = '0;
        tests_run    = 0;
        tests_failed = 0;
        seed_sink    = $urandom(32'h87aa4279);
        fill_table();
        // Two idle results are already in flight when the first row goes in
        for (row = 0; row < 2; row++) begin
            expected_q.push_back(predict('0, '0, '0));
            name_q.push_back($sformatf("after_reset_%0d", row));
        end
        repeat (reset_cycles) @(posedge clock);
        rst_n <= 1'b1;
        for (row = 0; row < num_rows + 2; row++) begin
            @(posedge clock);
            if (row < num_rows) begin
                request      <= row_request[row];
                read_status  <= row_read_status[row];
                write_status <= row_write_status[row];
                expected_q.push_back(predict(row_request[row], row_read_status[row],
                                             row_write_status[row]));
                name_q.push_back(row_name[row]);
            end
            // Mid-cycle, the result of the row driven two edges back is stable
            @(negedge clock);
            check_outputs();
        end
        $display("Tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== test/io_predication_sva.sv ====
// Ready gate assertions
// A stalled instruction drives no port enable, and each enable picks at most one port

`include "io_pred_defs.svh"

module io_predication_sva (
    input logic                      clock,
    input logic                      rst_n,
    input logic                      io_ready,
    input logic [`IO_PORT_COUNT-1:0] rden,
    input logic [`IO_PORT_COUNT-1:0] wren
);

    // Low io_ready annuls both sides
    annul_on_stall: assert property (@(posedge clock) disable iff (!rst_n)
        !io_ready |-> (rden == '0 && wren == '0))
        else $error("Port enable active while io_ready is low");

    rden_onehot: assert property (@(posedge clock) disable iff (!rst_n) $onehot0(rden))
        else $error("rden selects more than one read port");

    wren_onehot: assert property (@(posedge clock) disable iff (!rst_n) $onehot0(wren))
        else $error("wren selects more than one write port");

endmodule

// The gate is combinational, so the checker sits on the stage top where its outputs leave
bind io_predication_top io_predication_sva i_sva (
    .clock    (clock),
    .rst_n    (rst_n),
    .io_ready (io_ready),
    .rden     (rden),
    .wren     (wren)
);

// ==== hdl/io_predication_top.sv ====
// I/O predication stage
// Read side and write side in parallel, merged by the ready gate two cycles later

`include "io_pred_defs.svh"

module io_predication_top (
    input  logic                      clock,
    input  logic                      rst_n,
    input  io_pred_pkg::io_request_t  request,
    input  logic [`IO_PORT_COUNT-1:0] read_status,
    input  logic [`IO_PORT_COUNT-1:0] write_status,
    output logic                      io_ready,
    output logic [`IO_PORT_COUNT-1:0] rden,
    output logic [`IO_PORT_COUNT-1:0] wren,
    output logic [`IO_DATA_WIDTH-1:0] wdata,
    output logic                      read_is_io
);

    import io_pred_pkg::*;

    // Both side results are aligned to stage 2
    io_side_result_t           read_result;
    io_side_result_t           write_result;
    logic [`IO_DATA_WIDTH-1:0] wdata_aligned;

    // ------------------------------------------------------------------
    // Sides

    io_read_predication i_read (
        .clock        (clock),
        .rst_n        (rst_n),
        .valid        (request.valid),
        .read_addr    (request.read_addr),
        .read_status  (read_status),
        .read_result  (read_result)
    );

    io_write_predication i_write (
        .clock         (clock),
        .rst_n         (rst_n),
        .valid         (request.valid),
        .write_addr    (request.write_addr),
        .write_data    (request.write_data),
        .write_status  (write_status),
        .write_result  (write_result),
        .wdata_aligned (wdata_aligned)
    );

    // ------------------------------------------------------------------
    // Gate, combinational

    io_ready_gate i_gate (
        .read_result   (read_result),
        .write_result  (write_result),
        .wdata_aligned (wdata_aligned),
        .io_ready      (io_ready),
        .rden          (rden),
        .wren          (wren),
        .wdata         (wdata),
        .read_is_io    (read_is_io)
    );

endmodule

// ==== hdl/io_ready_gate.sv ====
// I/O ready gate
// Merges both side results into io_ready and annuls the port enables on a stall

`include "io_pred_defs.svh"

module io_ready_gate (
    input  io_pred_pkg::io_side_result_t read_result,
    input  io_pred_pkg::io_side_result_t write_result,
    input  logic [`IO_DATA_WIDTH-1:0]    wdata_aligned,
    output logic                         io_ready,
    output logic [`IO_PORT_COUNT-1:0]    rden,
    output logic [`IO_PORT_COUNT-1:0]    wren,
    output logic [`IO_DATA_WIDTH-1:0]    wdata,
    output logic                         read_is_io
);

    // ------------------------------------------------------------------
    // Ready decision

    // The instruction goes ahead only if neither side hit a busy port
    assign io_ready = !(read_result.busy || write_result.busy);

    // ------------------------------------------------------------------
    // Enable annulling
    // A stalled instruction must not pop a read port or push a write port,
    // otherwise its replay would lose or duplicate port data

    logic [`IO_PORT_COUNT-1:0] keep_mask;

    assign keep_mask = {`IO_PORT_COUNT{io_ready}};

    assign rden = read_result.select  & keep_mask;
    assign wren = write_result.select & keep_mask;

    // ------------------------------------------------------------------
    // Pass-through to later stages

    // Data is only meaningful where wren is set
    assign wdata = wdata_aligned;

    // Decode reused downstream, reported even when stalled
    assign read_is_io = read_result.is_io;

endmodule

// ==== hdl/io_write_predication.sv ====
// I/O write predication
// Decides whether the write destination may touch its port, carrying the data along

`include "io_pred_defs.svh"

module io_write_predication (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         valid,
    input  logic [`IO_ADDR_WIDTH-1:0]    write_addr,
    input  logic [`IO_DATA_WIDTH-1:0]    write_data,
    input  logic [`IO_PORT_COUNT-1:0]    write_status,
    output io_pred_pkg::io_side_result_t write_result,
    output logic [`IO_DATA_WIDTH-1:0]    wdata_aligned
);

    import io_pred_pkg::*;

    // ------------------------------------------------------------------
    // Write ports are ready when not full
    // A full write port has no room, so it blocks the instruction

    localparam bit write_ready_level = 1'b0;

    // ------------------------------------------------------------------
    // Address view

    io_addr_u write_word;

    assign write_word.raw = write_addr;

    // ------------------------------------------------------------------
    // Port check, two cycles

    io_port_check #(
        .ready_high  (write_ready_level)
    ) i_write_check (
        .clock       (clock),
        .rst_n       (rst_n),
        .valid       (valid),
        .addr        (write_word),
        .port_status (write_status),
        .result      (write_result)
    );

    // ------------------------------------------------------------------
    // Data delay
    // Two registers match the checker, so data and enable reach the gate together

    logic [`IO_DATA_WIDTH-1:0] wdata_s1;

    // Plain payload, qualified later by wren
    always_ff @(posedge clock) begin
        wdata_s1      <= write_data;
        wdata_aligned <= wdata_s1;
    end

endmodule

// ==== hdl/io_read_predication.sv ====
// I/O read predication
// Decides whether the read operand may touch its port this instruction

`include "io_pred_defs.svh"

module io_read_predication (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         valid,
    input  logic [`IO_ADDR_WIDTH-1:0]    read_addr,
    input  logic [`IO_PORT_COUNT-1:0]    read_status,
    output io_pred_pkg::io_side_result_t read_result
);

    import io_pred_pkg::*;

    // ------------------------------------------------------------------
    // Read ports are ready when full
    // An empty read port has nothing to give, so it blocks the instruction

    localparam bit read_ready_level = 1'b1;

    // ------------------------------------------------------------------
    // Address view

    io_addr_u read_word;

    // The pipeline hands over a plain address; the checker wants the port view
    assign read_word.raw = read_addr;

    // ------------------------------------------------------------------
    // Port check
    // Its result lands at stage 2, which is where the gate expects it

    io_port_check #(
        .ready_high  (read_ready_level)
    ) i_read_check (
        .clock       (clock),
        .rst_n       (rst_n),
        .valid       (valid),
        .addr        (read_word),
        .port_status (read_status),
        .result      (read_result)
    );

    // read_result.is_io is kept past the gate
    // so later stages reuse the decode instead of comparing the address again

endmodule

// ==== hdl/io_port_check.sv ====
// I/O port check
// Two-stage decode of one address against the port window and its status

`include "io_pred_defs.svh"

module io_port_check #(
    // Status level at which a port counts as ready
    parameter bit ready_high = 1'b1
) (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         valid,
    input  io_pred_pkg::io_addr_u        addr,
    input  logic [`IO_PORT_COUNT-1:0]    port_status,
    output io_pred_pkg::io_side_result_t result
);

    // Window tag of the base address, taken from the upper address bits
    localparam logic [`IO_ADDR_WIDTH-1:0] base_addr = `IO_PORT_BASE;
    localparam logic [`IO_PORT_TAG_WIDTH-1:0] base_tag =
        base_addr[`IO_ADDR_WIDTH-1:`IO_PORT_INDEX_WIDTH];

    // ------------------------------------------------------------------
    // Stage 1: window compare, capture index and status

    logic                            s1_is_io;
    logic [`IO_PORT_INDEX_WIDTH-1:0] s1_index;
    logic [`IO_PORT_COUNT-1:0]       s1_status;

    // Only the I/O flag is control state
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s1_is_io <= 1'b0;
        end else begin
            s1_is_io <= valid && (addr.port.tag == base_tag);
        end
    end

    // Index and status are sampled on the same edge as the address
    always_ff @(posedge clock) begin
        s1_index  <= addr.port.index;
        s1_status <= port_status;
    end

    // ------------------------------------------------------------------
    // Stage 2: one-hot select and busy mask

    logic [`IO_PORT_COUNT-1:0] s1_onehot;
    logic                      s1_busy;

    // A non-I/O access selects no port at all
    assign s1_onehot = {`IO_PORT_COUNT{s1_is_io}} &
                       ({{(`IO_PORT_COUNT-1){1'b0}}, 1'b1} << s1_index);

    // The hit port stalls the instruction unless it sits at its ready level
    assign s1_busy = s1_is_io && (s1_status[s1_index] != ready_high);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result.is_io  <= 1'b0;
            result.busy   <= 1'b0;
            result.select <= '0;
        end else begin
            result.is_io  <= s1_is_io;
            result.busy   <= s1_busy;
            result.select <= s1_onehot;
        end
    end

endmodule

// ==== hdl/io_pred_pkg.sv ====
// I/O predication types
// Request bundle, the two views of an address word and the per-side result

`include "io_pred_defs.svh"

package io_pred_pkg;

    // ------------------------------------------------------------------
    // One instruction as the pipeline presents it each cycle

    typedef struct packed {
        logic                          valid;
        logic [`IO_ADDR_WIDTH-1:0]     read_addr;
        logic [`IO_ADDR_WIDTH-1:0]     write_addr;
        logic [`IO_DATA_WIDTH-1:0]     write_data;
    } io_request_t;

    // ------------------------------------------------------------------
    // Address word seen as a port access
    // The tag picks the window and the index picks a port inside it

    typedef struct packed {
        logic [`IO_PORT_TAG_WIDTH-1:0]   tag;
        logic [`IO_PORT_INDEX_WIDTH-1:0] index;
    } io_port_addr_t;

    // The same word is either a plain memory address or a port access
    typedef union packed {
        logic [`IO_ADDR_WIDTH-1:0] raw;
        io_port_addr_t             port;
    } io_addr_u;

    // ------------------------------------------------------------------
    // What one side reports to the ready gate at stage 2

    typedef struct packed {
        logic                      is_io;
        logic                      busy;
        logic [`IO_PORT_COUNT-1:0] select;
    } io_side_result_t;

endpackage

// ==== hdl/io_pred_defs.svh ====
// I/O predication constants
// Address, port window and data sizes shared by the package and the RTL

`ifndef IO_PRED_DEFS_SVH
`define IO_PRED_DEFS_SVH

// ----------------------------------------------------------------------
// Address layout

// Width of one operand address word
`define IO_ADDR_WIDTH 10

// Number of memory-mapped ports on each side, read and write
`define IO_PORT_COUNT 4

// The port index sits in the low address bits
`define IO_PORT_INDEX_WIDTH 2

// Upper address bits that tag an address as belonging to the port window
`define IO_PORT_TAG_WIDTH (`IO_ADDR_WIDTH - `IO_PORT_INDEX_WIDTH)

// First address of the port window
// It is aligned to the port count, so a tag compare alone finds I/O
`define IO_PORT_BASE 10'h3F0

// ----------------------------------------------------------------------
// Payload

// Width of the data carried to a write port
`define IO_DATA_WIDTH 16

`endif
